// File: src.f
mrp_pkg.sv
mrp_hdr_capture.sv
mrp_log_buffer.sv
mrp_log_reader.sv
mrp_logger_top.sv
mrp_logger_properties.sv
tb_mrp_logger.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mrp_logger
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST OK

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_mrp_logger.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mrp_logger;

    localparam int clk_period = 8;
    localparam int resp_timeout = 300;
    localparam int depth = 2**mrp_pkg::log_depth_log2;

    logic                               clk;
    logic                               rst;
    logic                               rx_data_val;
    logic [mrp_pkg::mac_data_w-1:0]     rx_data;
    logic                               rx_last;
    logic [mrp_pkg::mac_padbytes_w-1:0] rx_padbytes;
    logic                               rx_rdy;
    logic [mrp_pkg::chksum_w-1:0]       chksum;
    logic                               cmd_queue_empty = 1'b1;
    logic [mrp_pkg::cmd_w-1:0]          cmd_queue_rd_data = '0;
    logic                               cmd_queue_rd_req;
    logic                               rd_resp_val;
    logic [mrp_pkg::cmd_w-1:0]          rd_resp_data;

    logic [31:0] lfsr_state = 32'd92873;

    // show-ahead queue model, expected responses and pop times.
    logic [mrp_pkg::cmd_w-1:0] cmd_q[$];
    logic [mrp_pkg::cmd_w-1:0] exp_q[$];
    int pop_cycle_q[$];
    int cycle = 0;
    int resp_count = 0;
    int cmd_count = 0;

    // reference model of the logger.
    logic [mrp_pkg::cnt_w-1:0] m_recv = '0;
    logic [mrp_pkg::cnt_w-1:0] m_drop = '0;
    logic [mrp_pkg::cnt_w-1:0] m_wr_count = '0;
    logic [mrp_pkg::hdr_w-1:0] m_log [depth];
    logic m_in_pkt = 1'b0;

    mrp_logger_top dut0 (
        .clk               (clk),
        .rst               (rst),
        .rx_data_val       (rx_data_val),
        .rx_data           (rx_data),
        .rx_last           (rx_last),
        .rx_padbytes       (rx_padbytes),
        .rx_rdy            (rx_rdy),
        .chksum            (chksum),
        .cmd_queue_empty   (cmd_queue_empty),
        .cmd_queue_rd_data (cmd_queue_rd_data),
        .cmd_queue_rd_req  (cmd_queue_rd_req),
        .rd_resp_val       (rd_resp_val),
        .rd_resp_data      (rd_resp_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one lfsr step per bit taken.
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        if (act !== exp) begin
            $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // pop on a sampled request, then show the new head.
    always @(posedge clk) begin
        if (cmd_queue_rd_req) begin
            if (cmd_q.size() == 0) begin
                abort_run("read request seen while the command queue model is empty");
            end else begin
                void'(cmd_q.pop_front());
                pop_cycle_q.push_back(cycle);
            end
        end
        cmd_queue_empty <= (cmd_q.size() == 0);
        cmd_queue_rd_data <= (cmd_q.size() != 0) ? cmd_q[0] : '0;
    end

    always @(posedge clk) begin
        if (!rst && rd_resp_val) begin
            if (exp_q.size() == 0 || pop_cycle_q.size() == 0) begin
                abort_run("read response arrived with no command in flight");
            end else begin
                check_value("rd_resp_val cycle", 64'(pop_cycle_q.pop_front() + 2), 64'(cycle));
                check_value("rd_resp_data", exp_q.pop_front(), rd_resp_data);
                resp_count <= resp_count + 1;
            end
        end
    end

    function automatic logic [63:0] expected_resp(input logic [63:0] cmd);
        logic [mrp_pkg::op_w-1:0] op;
        op = cmd[mrp_pkg::op_lsb +: mrp_pkg::op_w];
        case (op)
            mrp_pkg::op_rd_recv: return 64'(m_recv);
            mrp_pkg::op_rd_drop: return 64'(m_drop);
            mrp_pkg::op_rd_entry: return 64'(m_log[cmd[mrp_pkg::log_depth_log2-1:0]]);
            default: return 64'(m_wr_count);
        endcase
    endfunction

    // unused command bits carry random filler.
    task automatic push_cmd(input logic [mrp_pkg::op_w-1:0] op,
                            input logic [mrp_pkg::log_depth_log2-1:0] idx);
        logic [63:0] cmd;
        cmd = rand_bits(64);
        cmd[mrp_pkg::op_lsb +: mrp_pkg::op_w] = op;
        cmd[mrp_pkg::log_depth_log2-1:0] = idx;
        cmd_q.push_back(cmd);
        exp_q.push_back(expected_resp(cmd));
        cmd_count++;
    endtask

    task automatic wait_responses();
        int waited;
        waited = 0;
        while (resp_count != cmd_count) begin
            if (waited >= resp_timeout) begin
                abort_run("timeout while waiting for read responses");
            end else begin
                @(posedge clk);
                waited++;
            end
        end
    endtask

    task automatic model_accept(input logic [63:0] data, input logic [15:0] cks,
                                input logic last);
        if (!m_in_pkt) begin
            m_recv++;
            if (cks != '0) begin
                m_drop++;
            end
            m_log[m_wr_count[mrp_pkg::log_depth_log2-1:0]] = data[mrp_pkg::hdr_w-1:0];
            m_wr_count++;
            m_in_pkt = !last;
        end else if (last) begin
            m_in_pkt = 1'b0;
        end
    endtask

    // gaps come from valid low or rdy low and junk data is never logged.
    task automatic send_packet();
        int n_beats;
        int tries;
        logic accepted;
        logic vld;
        logic rdy;
        logic [63:0] data;
        logic [15:0] cks;
        n_beats = 32'(rand_bits(2)) + 1;
        for (int b = 0; b < n_beats; b++) begin
            accepted = 1'b0;
            tries = 0;
            while (!accepted) begin
                @(posedge clk);
                data = rand_bits(64);
                cks = (rand_bits(1) == 64'd0) ? 16'd0 : 16'(rand_bits(16));
                vld = (rand_bits(2) != 64'd0);
                rdy = (rand_bits(2) != 64'd0);
                if (tries >= 8) begin
                    vld = 1'b1;
                    rdy = 1'b1;
                end
                rx_data_val <= vld;
                rx_rdy <= rdy;
                rx_data <= data;
                rx_last <= (b == n_beats - 1);
                chksum <= cks;
                rx_padbytes <= 3'(rand_bits(3));
                if (vld && rdy) begin
                    accepted = 1'b1;
                    model_accept(data, cks, b == n_beats - 1);
                end
                tries++;
            end
        end
    endtask

    task automatic quiet_stream();
        @(posedge clk);
        rx_data_val <= 1'b0;
        rx_last <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    task automatic read_all(input int n_entries);
        @(negedge clk);
        push_cmd(mrp_pkg::op_rd_recv, '0);
        push_cmd(mrp_pkg::op_rd_drop, '0);
        push_cmd(mrp_pkg::op_rd_wr_count, '0);
        for (int i = 0; i < n_entries; i++) begin
            push_cmd(mrp_pkg::op_rd_entry, 4'(i));
        end
        wait_responses();
    endtask

    initial begin
        rst = 1'b1;
        rx_data_val = 1'b0;
        rx_data = '0;
        rx_last = 1'b0;
        rx_padbytes = '0;
        rx_rdy = 1'b0;
        chksum = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);

        // counters read zero after reset.
        read_all(0);

        repeat (10) send_packet();
        quiet_stream();
        read_all(10);

        // more than a full ring, so the oldest entries are overwritten.
        repeat (20) send_packet();
        quiet_stream();
        read_all(depth);

        @(negedge clk);
        for (int i = 0; i < 24; i++) begin
            push_cmd(2'(rand_bits(2)), 4'(rand_bits(4)));
        end
        wait_responses();

        // a stray response in these idle cycles stops the run.
        repeat (4) @(posedge clk);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: mrp_logger_properties.sv
`timescale 1ns/1ns
`default_nettype none

module mrp_logger_properties (
    input wire clk,
    input wire rst,
    input wire cmd_queue_empty,
    input wire cmd_queue_rd_req,
    input wire rd_resp_val
);

    // each pop gets one response exactly two cycles later.
    resp_after_req: assert property (@(posedge clk) disable iff (rst)
        $past(cmd_queue_rd_req, 2) |-> rd_resp_val)
        else $error("rd_resp_val missing two cycles after rd_req");

    resp_needs_req: assert property (@(posedge clk) disable iff (rst)
        rd_resp_val |-> $past(cmd_queue_rd_req, 2))
        else $error("rd_resp_val without rd_req two cycles before");

    // a pop needs a visible command and no other command in flight.
    req_legal: assert property (@(posedge clk) disable iff (rst)
        cmd_queue_rd_req |->
            (!cmd_queue_empty && !$past(cmd_queue_rd_req) && !$past(cmd_queue_rd_req, 2)))
        else $error("rd_req while the queue is empty or a command is in flight");

    quiet_in_reset: assert property (@(posedge clk)
        (rst && $past(rst)) |-> (!cmd_queue_rd_req && !rd_resp_val))
        else $error("rd_req or rd_resp_val high during reset");

endmodule

bind mrp_logger_top mrp_logger_properties props0 (
    .clk              (clk),
    .rst              (rst),
    .cmd_queue_empty  (cmd_queue_empty),
    .cmd_queue_rd_req (cmd_queue_rd_req),
    .rd_resp_val      (rd_resp_val)
);

`default_nettype wire

// File: mrp_logger_top.sv
`timescale 1ns/1ns
`default_nettype none

module mrp_logger_top (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                rx_data_val,
    input  wire  [mrp_pkg::mac_data_w-1:0]     rx_data,
    input  wire                                rx_last,
    // the logger only reads the first beat and never uses the pad count.
    input  wire  [mrp_pkg::mac_padbytes_w-1:0] rx_padbytes,
    input  wire                                rx_rdy,
    input  wire  [mrp_pkg::chksum_w-1:0]       chksum,
    input  wire                                cmd_queue_empty,
    input  wire  [mrp_pkg::cmd_w-1:0]          cmd_queue_rd_data,
    output logic                               cmd_queue_rd_req,
    output logic                               rd_resp_val,
    output logic [mrp_pkg::cmd_w-1:0]          rd_resp_data
);

    logic                               hdr_val;
    logic [mrp_pkg::hdr_w-1:0]          hdr;
    logic [mrp_pkg::cnt_w-1:0]          pkts_recv;
    logic [mrp_pkg::cnt_w-1:0]          pkts_dropped;
    logic [mrp_pkg::cnt_w-1:0]          wr_count;
    logic [mrp_pkg::log_depth_log2-1:0] buf_rd_addr;
    logic [mrp_pkg::hdr_w-1:0]          buf_rd_data;

    mrp_hdr_capture capture0 (
        .clk          (clk),
        .rst          (rst),
        .rx_data_val  (rx_data_val),
        .rx_data      (rx_data),
        .rx_last      (rx_last),
        .rx_rdy       (rx_rdy),
        .chksum       (chksum),
        .hdr_val      (hdr_val),
        .hdr          (hdr),
        .pkts_recv    (pkts_recv),
        .pkts_dropped (pkts_dropped)
    );

    mrp_log_buffer buffer0 (
        .clk      (clk),
        .rst      (rst),
        .hdr_val  (hdr_val),
        .hdr      (hdr),
        .rd_addr  (buf_rd_addr),
        .rd_data  (buf_rd_data),
        .wr_count (wr_count)
    );

    mrp_log_reader reader0 (
        .clk               (clk),
        .rst               (rst),
        .cmd_queue_empty   (cmd_queue_empty),
        .cmd_queue_rd_data (cmd_queue_rd_data),
        .pkts_recv         (pkts_recv),
        .pkts_dropped      (pkts_dropped),
        .wr_count          (wr_count),
        .buf_rd_data       (buf_rd_data),
        .cmd_queue_rd_req  (cmd_queue_rd_req),
        .buf_rd_addr       (buf_rd_addr),
        .rd_resp_val       (rd_resp_val),
        .rd_resp_data      (rd_resp_data)
    );

endmodule

`default_nettype wire

// File: mrp_log_reader.sv
`timescale 1ns/1ns
`default_nettype none

module mrp_log_reader (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                cmd_queue_empty,
    input  wire  [mrp_pkg::cmd_w-1:0]          cmd_queue_rd_data,
    input  wire  [mrp_pkg::cnt_w-1:0]          pkts_recv,
    input  wire  [mrp_pkg::cnt_w-1:0]          pkts_dropped,
    input  wire  [mrp_pkg::cnt_w-1:0]          wr_count,
    input  wire  [mrp_pkg::hdr_w-1:0]          buf_rd_data,
    output logic                               cmd_queue_rd_req,
    output logic [mrp_pkg::log_depth_log2-1:0] buf_rd_addr,
    output logic                               rd_resp_val,
    output logic [mrp_pkg::cmd_w-1:0]          rd_resp_data
);

    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_addr = 2'd1,
        st_resp = 2'd2
    } state_t;

    state_t state_reg;
    state_t state_next;

    logic [mrp_pkg::op_w-1:0]  op_reg;
    logic [mrp_pkg::cmd_w-1:0] resp_next;

    // pop the head command as soon as we are free.
    assign cmd_queue_rd_req = (state_reg == st_idle) & ~cmd_queue_empty;

    // the head is already visible, so the buffer sees the index at the pop edge.
    assign buf_rd_addr = cmd_queue_rd_data[mrp_pkg::log_depth_log2-1:0];

    always_comb begin
        state_next = state_reg;
        case (state_reg)
            st_idle: begin
                if (cmd_queue_rd_req) begin
                    state_next = st_addr;
                end
            end
            st_addr: begin
                state_next = st_resp;
            end
            st_resp: begin
                state_next = st_idle;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    // everything is zero-extended to the response width.
    always_comb begin
        resp_next = '0;
        case (op_reg)
            mrp_pkg::op_rd_recv: resp_next[mrp_pkg::cnt_w-1:0] = pkts_recv;
            mrp_pkg::op_rd_drop: resp_next[mrp_pkg::cnt_w-1:0] = pkts_dropped;
            mrp_pkg::op_rd_entry: resp_next[mrp_pkg::hdr_w-1:0] = buf_rd_data;
            default: resp_next[mrp_pkg::cnt_w-1:0] = wr_count;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= st_idle;
            rd_resp_val <= 1'b0;
        end else begin
            state_reg <= state_next;
            rd_resp_val <= (state_reg == st_addr);
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_queue_rd_req) begin
            op_reg <= cmd_queue_rd_data[mrp_pkg::op_lsb +: mrp_pkg::op_w];
        end
        if (state_reg == st_addr) begin
            rd_resp_data <= resp_next;
        end
    end

endmodule

`default_nettype wire

// File: mrp_log_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module mrp_log_buffer (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                hdr_val,
    input  wire  [mrp_pkg::hdr_w-1:0]          hdr,
    input  wire  [mrp_pkg::log_depth_log2-1:0] rd_addr,
    output logic [mrp_pkg::hdr_w-1:0]          rd_data,
    output logic [mrp_pkg::cnt_w-1:0]          wr_count
);

    logic [mrp_pkg::hdr_w-1:0] mem [2**mrp_pkg::log_depth_log2];

    logic [mrp_pkg::log_depth_log2-1:0] wr_ptr;

    // write pointer wraps with the count, so the oldest entry goes first.
    assign wr_ptr = wr_count[mrp_pkg::log_depth_log2-1:0];

    always_ff @(posedge clk) begin
        if (hdr_val) begin
            mem[wr_ptr] <= hdr;
        end
    end

    // registered read port.
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_count <= '0;
        end else if (hdr_val) begin
            wr_count <= wr_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: mrp_hdr_capture.sv
`timescale 1ns/1ns
`default_nettype none

module mrp_hdr_capture (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            rx_data_val,
    input  wire  [mrp_pkg::mac_data_w-1:0] rx_data,
    input  wire                            rx_last,
    input  wire                            rx_rdy,
    input  wire  [mrp_pkg::chksum_w-1:0]   chksum,
    output logic                           hdr_val,
    output logic [mrp_pkg::hdr_w-1:0]      hdr,
    output logic [mrp_pkg::cnt_w-1:0]      pkts_recv,
    output logic [mrp_pkg::cnt_w-1:0]      pkts_dropped
);

    typedef enum logic {
        st_idle   = 1'b0,
        st_in_pkt = 1'b1
    } state_t;

    state_t state_reg;
    state_t state_next;

    logic beat_acc;
    logic first_beat;

    assign beat_acc = rx_data_val & rx_rdy;

    // only a beat accepted while idle opens a packet.
    assign first_beat = beat_acc & (state_reg == st_idle);

    always_comb begin
        state_next = state_reg;
        case (state_reg)
            st_idle: begin
                // a single-beat packet never leaves idle.
                if (first_beat & ~rx_last) begin
                    state_next = st_in_pkt;
                end
            end
            st_in_pkt: begin
                if (beat_acc & rx_last) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= st_idle;
            hdr_val <= 1'b0;
            pkts_recv <= '0;
            pkts_dropped <= '0;
        end else begin
            state_reg <= state_next;
            hdr_val <= first_beat;
            if (first_beat) begin
                pkts_recv <= pkts_recv + 1'b1;
                // a bad checksum is only counted and the entry is still logged.
                if (chksum != '0) begin
                    pkts_dropped <= pkts_dropped + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (first_beat) begin
            hdr <= rx_data[mrp_pkg::hdr_w-1:0];
        end
    end

endmodule

`default_nettype wire

// File: mrp_pkg.sv
`default_nettype none

package mrp_pkg;

    // receive stream fields.
    localparam int mac_data_w = 64;
    localparam int mac_padbytes_w = 3;
    localparam int chksum_w = 16;

    // one log entry is the low part of the first beat.
    localparam int hdr_w = 48;

    // packet and entry counters.
    localparam int cnt_w = 32;

    // log ring holds 2**log_depth_log2 entries.
    localparam int log_depth_log2 = 4;

    // command and response words.
    localparam int cmd_w = 64;

    // opcode field sits in the top two bits of a command.
    localparam int op_w = 2;
    localparam int op_lsb = 62;

    // read the received packet count.
    localparam logic [op_w-1:0] op_rd_recv = 2'd0;

    // read the dropped packet count.
    localparam logic [op_w-1:0] op_rd_drop = 2'd1;

    // read one log entry, index in the low command bits.
    localparam logic [op_w-1:0] op_rd_entry = 2'd2;

    // read the number of entries ever written.
    localparam logic [op_w-1:0] op_rd_wr_count = 2'd3;

endpackage

`default_nettype wire
